//--- Bender.yml
package:
  name: credit_fifo

sources:
  # Packages first, then leaf modules, then the top level
  - src/credit_fifo_cfg_pkg.sv
  - src/credit_fifo_types_pkg.sv
  - src/ram_flops.sv
  - src/pop_output_reg.sv
  - src/fifo_ctrl_1r1w.sv
  - src/credit_push_ctrl.sv
  - src/credit_fifo_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/credit_fifo_tb.sv

//--- credit_fifo.f
src/credit_fifo_cfg_pkg.sv
src/credit_fifo_types_pkg.sv
src/ram_flops.sv
src/pop_output_reg.sv
src/fifo_ctrl_1r1w.sv
src/credit_push_ctrl.sv
src/credit_fifo_top.sv
tb/tb_clock_gen.sv
tb/credit_fifo_tb.sv

//--- src/credit_fifo_cfg_pkg.sv
/* Sizing constants for the credit-flow receive buffer.
   Every RTL file reads these through scoped names. */

`default_nettype none

package credit_fifo_cfg_pkg;

  // ----------------------------------------------------------------------
  // Buffer geometry
  // ----------------------------------------------------------------------

  // Number of flop RAM entries, which is also the most credits ever owed
  localparam int depth = 8;
  // Payload bits carried by each flit
  localparam int data_width = 32;
  // Sequence tag carried next to the payload
  localparam int tag_width = 8;

  // ----------------------------------------------------------------------
  // Derived widths and constants
  // ----------------------------------------------------------------------

  // Item and slot counts must be able to hold the value depth itself
  localparam int count_width = $clog2(depth + 1);
  localparam int credit_width = $clog2(depth + 1);
  localparam int addr_width = 3;

  // Pointer value at which both RAM pointers wrap back to zero
  localparam logic [addr_width-1:0] last_addr = addr_width'(depth - 1);
  // Depth expressed at counter width, for full and slot math
  localparam logic [count_width-1:0] depth_count = count_width'(depth);
  localparam logic [credit_width-1:0] depth_credit = credit_width'(depth);

endpackage

`default_nettype wire

//--- src/credit_fifo_top.sv
/* Credit-flow receive buffer top level. Ties the credit counter, the FIFO
   controller, the flop RAM and the registered pop stage together. */

`timescale 1ns/10ps
`default_nettype none

module credit_fifo_top (
  input  wire logic                                         clk,
  input  wire logic                                         reset,
  // Credit control
  input  wire logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_initial,
  input  wire logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_withhold,
  input  wire logic                                         push_credit_stall,
  // Push port, credit-valid
  output logic                                              push_credit,
  input  wire logic                                         push_valid,
  input  wire credit_fifo_types_pkg::flit_t                 push_flit,
  // Pop port, ready-valid
  input  wire logic                                         pop_ready,
  output logic                                              pop_valid,
  output credit_fifo_types_pkg::flit_t                      pop_flit,
  // Status
  output credit_fifo_types_pkg::occupancy_t                 occupancy,
  output credit_fifo_types_pkg::credit_status_t             credit_status
);

  // ----------------------------------------------------------------------
  // Internal nets
  // ----------------------------------------------------------------------

  logic                                       slot_release;
  logic                                       head_valid;
  logic                                       head_take;
  credit_fifo_types_pkg::flit_t               head_flit;
  logic                                       wr_en;
  logic [credit_fifo_cfg_pkg::addr_width-1:0] wr_addr;
  credit_fifo_types_pkg::flit_t               wr_flit;
  logic [credit_fifo_cfg_pkg::addr_width-1:0] rd_addr;
  credit_fifo_types_pkg::flit_t               rd_flit;

  // Input side returns one credit per slot freed in the RAM
  credit_push_ctrl u_credit_push_ctrl (
    .clk               (clk),
    .reset             (reset),
    .credit_initial    (credit_initial),
    .credit_withhold   (credit_withhold),
    .push_credit_stall (push_credit_stall),
    .slot_release      (slot_release),
    .push_credit       (push_credit),
    .credit_status     (credit_status)
  );

  fifo_ctrl_1r1w u_fifo_ctrl_1r1w (
    .clk          (clk),
    .reset        (reset),
    .push_valid   (push_valid),
    .push_flit    (push_flit),
    .head_take    (head_take),
    .head_valid   (head_valid),
    .head_flit    (head_flit),
    .slot_release (slot_release),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_flit      (wr_flit),
    .rd_addr      (rd_addr),
    .rd_flit      (rd_flit),
    .occupancy    (occupancy)
  );

  ram_flops u_ram_flops (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_flit (wr_flit),
    .rd_addr (rd_addr),
    .rd_flit (rd_flit)
  );

  // Output side adds the cycle that keeps the pop port flop-driven
  pop_output_reg u_pop_output_reg (
    .clk        (clk),
    .reset      (reset),
    .head_valid (head_valid),
    .head_flit  (head_flit),
    .head_take  (head_take),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_flit   (pop_flit)
  );

endmodule

`default_nettype wire

//--- src/credit_fifo_types_pkg.sv
/* Packed structs shared by the buffer: the flit payload and the
   occupancy and credit status bundles exported by the top level. */

`default_nettype none

package credit_fifo_types_pkg;

  // ----------------------------------------------------------------------
  // Payload
  // ----------------------------------------------------------------------

  // One flit as pushed, stored in the RAM and popped
  typedef struct packed {
    logic [credit_fifo_cfg_pkg::data_width-1:0] data;
    // Sender sequence number, carried through untouched
    logic [credit_fifo_cfg_pkg::tag_width-1:0] tag;
  } flit_t;

  // ----------------------------------------------------------------------
  // Status bundles
  // ----------------------------------------------------------------------

  // RAM occupancy; slots is always depth minus items
  typedef struct packed {
    logic full;
    logic empty;
    logic [credit_fifo_cfg_pkg::count_width-1:0] items;
    logic [credit_fifo_cfg_pkg::count_width-1:0] slots;
  } occupancy_t;

  // Credits still owed to the sender, before and after the withhold
  typedef struct packed {
    logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_count;
    logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_available;
  } credit_status_t;

endpackage

`default_nettype wire

//--- src/credit_push_ctrl.sv
/* Receiver-side credit counter for the push port. Slots freed by the
   FIFO come back as credits; one credit is granted per cycle when allowed. */

`timescale 1ns/10ps
`default_nettype none

module credit_push_ctrl (
  input  wire logic                                         clk,
  input  wire logic                                         reset,
  input  wire logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_initial,
  input  wire logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_withhold,
  input  wire logic                                         push_credit_stall,
  // One pulse per RAM entry read out by the controller
  input  wire logic                                         slot_release,
  output logic                                              push_credit,
  output credit_fifo_types_pkg::credit_status_t             credit_status
);

  // ----------------------------------------------------------------------
  // Credit counter
  // ----------------------------------------------------------------------

  // Credits the receiver still owes the sender
  logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_count;
  logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_count_next;
  // Owed credits left over once the withhold is taken off
  logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_available;

  // The withhold can exceed the count, so the difference floors at zero
  always_comb begin
    if (credit_count > credit_withhold) begin
      credit_available = credit_count - credit_withhold;
    end else begin
      credit_available = '0;
    end
  end

  // Grant a credit whenever one is available and the sender is not stalled
  assign push_credit = (credit_available != '0) && !push_credit_stall;

  // A release and a grant in the same cycle cancel each other out
  assign credit_count_next = credit_count + slot_release - push_credit;

  // The initial credit is sampled for as long as reset is held
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_count <= credit_initial;
    end else begin
      credit_count <= credit_count_next;
    end
  end

  assign credit_status.credit_count     = credit_count;
  assign credit_status.credit_available = credit_available;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Releases only follow earlier pushes, so the debt can never pass depth
  a_credit_bounded: assert property (
    @(posedge clk) disable iff (reset)
    credit_count <= credit_fifo_cfg_pkg::depth_credit
  );

endmodule

`default_nettype wire

//--- src/fifo_ctrl_1r1w.sv
/* Pointer and occupancy control for the 1R1W flop RAM. Pushes are
   written straight into the RAM and the RAM head is offered to the pop stage. */

`timescale 1ns/10ps
`default_nettype none

module fifo_ctrl_1r1w (
  input  wire logic                                       clk,
  input  wire logic                                       reset,
  // Push side, already credit-qualified by the sender
  input  wire logic                                       push_valid,
  input  wire credit_fifo_types_pkg::flit_t               push_flit,
  // Head offered to the pop stage
  input  wire logic                                       head_take,
  output logic                                            head_valid,
  output credit_fifo_types_pkg::flit_t                    head_flit,
  output logic                                            slot_release,
  // Flop RAM ports
  output logic                                            wr_en,
  output logic [credit_fifo_cfg_pkg::addr_width-1:0]      wr_addr,
  output credit_fifo_types_pkg::flit_t                    wr_flit,
  output logic [credit_fifo_cfg_pkg::addr_width-1:0]      rd_addr,
  input  wire credit_fifo_types_pkg::flit_t               rd_flit,
  output credit_fifo_types_pkg::occupancy_t               occupancy
);

  // ----------------------------------------------------------------------
  // Pointers
  // ----------------------------------------------------------------------

  logic [credit_fifo_cfg_pkg::addr_width-1:0] wr_ptr;
  logic [credit_fifo_cfg_pkg::addr_width-1:0] rd_ptr;
  // Entries currently held in the RAM
  logic [credit_fifo_cfg_pkg::count_width-1:0] items;
  logic full;
  logic empty;

  // Both pointers wrap at the last entry, so depth need not be a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (push_valid) begin
      if (wr_ptr == credit_fifo_cfg_pkg::last_addr) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (head_take) begin
      if (rd_ptr == credit_fifo_cfg_pkg::last_addr) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Occupancy
  // ----------------------------------------------------------------------

  // A push and a take in the same cycle leave the count unchanged
  always_ff @(posedge clk) begin
    if (reset) begin
      items <= '0;
    end else begin
      items <= items + push_valid - head_take;
    end
  end

  assign full  = (items == credit_fifo_cfg_pkg::depth_count);
  assign empty = (items == '0);

  assign occupancy.full  = full;
  assign occupancy.empty = empty;
  assign occupancy.items = items;
  assign occupancy.slots = credit_fifo_cfg_pkg::depth_count - items;

  // ----------------------------------------------------------------------
  // RAM control and head
  // ----------------------------------------------------------------------

  // Every push lands in the RAM, there is no bypass path to the pop side
  assign wr_en   = push_valid;
  assign wr_addr = wr_ptr;
  assign wr_flit = push_flit;

  // Read latency is zero, so the head is the word under the read pointer
  assign rd_addr    = rd_ptr;
  assign head_valid = !empty;
  assign head_flit  = rd_flit;

  // Each entry leaving the RAM frees one slot and so one credit
  assign slot_release = head_take;

  // A push while full means the sender pushed without holding a credit
  a_no_push_full: assert property (
    @(posedge clk) disable iff (reset)
    push_valid |-> !full
  );

  // The pop stage must only take a head that is actually offered
  a_no_take_empty: assert property (
    @(posedge clk) disable iff (reset)
    head_take |-> !empty
  );

endmodule

`default_nettype wire

//--- src/pop_output_reg.sv
/* One-entry forward register in front of the pop port. pop_valid and
   pop_flit come straight from flops and hold while the consumer stalls. */

`timescale 1ns/10ps
`default_nettype none

module pop_output_reg (
  input  wire logic                          clk,
  input  wire logic                          reset,
  input  wire logic                          head_valid,
  input  wire credit_fifo_types_pkg::flit_t  head_flit,
  output logic                               head_take,
  input  wire logic                          pop_ready,
  output logic                               pop_valid,
  output credit_fifo_types_pkg::flit_t       pop_flit
);

  // ----------------------------------------------------------------------
  // Forward register
  // ----------------------------------------------------------------------

  // The register can accept a new flit when it is empty or draining now
  logic load_en;

  assign load_en   = !pop_valid || pop_ready;
  assign head_take = head_valid && load_en;

  // Valid follows the head whenever the register is free to load
  always_ff @(posedge clk) begin
    if (reset) begin
      pop_valid <= 1'b0;
    end else if (load_en) begin
      pop_valid <= head_valid;
    end
  end

  // Payload only moves on an actual take
  always_ff @(posedge clk) begin
    if (head_take) begin
      pop_flit <= head_flit;
    end
  end

  // A stalled pop keeps both its valid and its flit until accepted
  a_pop_stable: assert property (
    @(posedge clk) disable iff (reset)
    (pop_valid && !pop_ready) |=> (pop_valid && $stable(pop_flit))
  );

endmodule

`default_nettype wire

//--- src/ram_flops.sv
/* Flop RAM with one write port and one combinational read port.
   Cells carry no reset, since the controller never reads an unwritten slot. */

`timescale 1ns/10ps
`default_nettype none

module ram_flops (
  input  wire logic                                  clk,
  input  wire logic                                  wr_en,
  input  wire logic [credit_fifo_cfg_pkg::addr_width-1:0] wr_addr,
  input  wire credit_fifo_types_pkg::flit_t          wr_flit,
  input  wire logic [credit_fifo_cfg_pkg::addr_width-1:0] rd_addr,
  output credit_fifo_types_pkg::flit_t               rd_flit
);

  // ----------------------------------------------------------------------
  // Storage
  // ----------------------------------------------------------------------

  credit_fifo_types_pkg::flit_t mem [credit_fifo_cfg_pkg::depth];

  // Write lands at the clock edge that ends the push cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_flit;
    end
  end

  // Zero-latency read, the controller keeps reads off the slot being written
  assign rd_flit = mem[rd_addr];

endmodule

`default_nettype wire

//--- tb/credit_fifo_tb.sv
/* Testbench for the credit-flow receive buffer. A credit-counting sender and a
   queue model drive random traffic and check every pop, status and grant. */

`timescale 1ns/10ps
`default_nettype none

module credit_fifo_tb;

  // ----------------------------------------------------------------------
  // Test lengths, in clock cycles
  // ----------------------------------------------------------------------

  localparam int reset_cycles = 3;
  localparam int random_cycles = 400;
  localparam int drain_cycles = 40;
  localparam int fill_cycles = 30;
  localparam int phase_cycles = 20;
  localparam int skew_cycles = 200;
  localparam int total_cycles = reset_cycles + random_cycles + drain_cycles + fill_cycles
                                + drain_cycles + 4 * phase_cycles + skew_cycles + drain_cycles;

  logic clk;
  logic reset;
  logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_initial;
  logic [credit_fifo_cfg_pkg::credit_width-1:0] credit_withhold;
  logic push_credit_stall;
  logic push_credit;
  logic push_valid;
  credit_fifo_types_pkg::flit_t push_flit;
  logic pop_ready;
  logic pop_valid;
  credit_fifo_types_pkg::flit_t pop_flit;
  credit_fifo_types_pkg::occupancy_t occupancy;
  credit_fifo_types_pkg::credit_status_t credit_status;

  // Model state: outstanding flits, sender credits and running totals
  credit_fifo_types_pkg::flit_t model_q[$];
  credit_fifo_types_pkg::flit_t prev_flit;
  logic prev_stalled;
  logic [31:0] lcg_state;
  logic [7:0] next_tag;
  int sender_credits;
  int granted_total;
  int pushed_total;
  int error_count;
  int check_count;
  int test_count;
  int mark_errors;
  int mark_checks;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  credit_fifo_top dut (
    .clk               (clk),
    .reset             (reset),
    .credit_initial    (credit_initial),
    .credit_withhold   (credit_withhold),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_flit         (push_flit),
    .pop_ready         (pop_ready),
    .pop_valid         (pop_valid),
    .pop_flit          (pop_flit),
    .occupancy         (occupancy),
    .credit_status     (credit_status)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Plain 32-bit LCG; the upper bits are the better ones
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic flag_error(input string msg);
    error_count++;
    $display("error at %0t: %0s", $time, msg);
  endtask

  task automatic check_flit(input credit_fifo_types_pkg::flit_t got,
                            input credit_fifo_types_pkg::flit_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %0s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_occupancy(input credit_fifo_types_pkg::occupancy_t got,
                                 input credit_fifo_types_pkg::occupancy_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: occupancy got items %0d full %b empty %b, expected %0d %b %b",
               $time, got.items, got.full, got.empty, exp.items, exp.full, exp.empty);
    end
  endtask

  task automatic check_credit(input credit_fifo_types_pkg::credit_status_t got,
                              input credit_fifo_types_pkg::credit_status_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: credit count/available got %0d/%0d expected %0d/%0d",
               $time, got.credit_count, got.credit_available,
               exp.credit_count, exp.credit_available);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t: %0s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // Called mid-cycle, once all outputs have settled for this cycle's inputs
  task automatic observe_cycle();
    credit_fifo_types_pkg::occupancy_t exp_occ;
    credit_fifo_types_pkg::credit_status_t exp_cred;
    credit_fifo_types_pkg::flit_t exp_flit;
    int ram_model;
    int exp_count;
    begin
      // Flits in the RAM are all outstanding ones minus the one in the output register
      ram_model = model_q.size() - (pop_valid ? 1 : 0);
      if (ram_model < 0) begin
        flag_error("pop_valid is high while no flit is outstanding");
        ram_model = 0;
      end
      exp_occ.full  = (ram_model == credit_fifo_cfg_pkg::depth);
      exp_occ.empty = (ram_model == 0);
      exp_occ.items = ram_model;
      exp_occ.slots = credit_fifo_cfg_pkg::depth - ram_model;
      check_occupancy(occupancy, exp_occ);
      // Every credit is either with the sender, owed, or tied to a flit in the RAM
      exp_count = credit_initial - sender_credits - ram_model - (push_valid ? 1 : 0);
      exp_cred.credit_count = exp_count;
      if (exp_count > credit_withhold) begin
        exp_cred.credit_available = exp_count - credit_withhold;
      end else begin
        exp_cred.credit_available = '0;
      end
      check_credit(credit_status, exp_cred);
      check_bit(push_credit, (exp_cred.credit_available != '0) && !push_credit_stall,
                "push_credit");
      if (push_valid && ram_model == credit_fifo_cfg_pkg::depth) begin
        flag_error("sender pushed while the RAM was full");
      end
      // A stalled pop must present the same flit again
      if (prev_stalled) begin
        check_bit(pop_valid, 1'b1, "stalled pop_valid");
        check_flit(pop_flit, prev_flit, "stalled pop_flit");
      end
      if (pop_valid && pop_ready) begin
        if (model_q.size() == 0) begin
          flag_error("pop transfer with no flit expected");
        end else begin
          exp_flit = model_q.pop_front();
          check_flit(pop_flit, exp_flit, "pop_flit");
        end
      end
      prev_stalled = pop_valid && !pop_ready;
      prev_flit = pop_flit;
      if (push_credit) begin
        granted_total++;
        sender_credits++;
      end
      if (granted_total > credit_initial + pushed_total - ram_model) begin
        flag_error("sender received more credits than slots were released");
      end
      if (push_valid) begin
        model_q.push_back(push_flit);
        pushed_total++;
      end
    end
  endtask

  // Entered 1 ns after a rising edge and returns 1 ns after the next one
  task automatic run_cycle(input logic want_push, input logic ready_in);
    credit_fifo_types_pkg::flit_t flit;
    begin
      pop_ready = ready_in;
      if (want_push && sender_credits > 0) begin
        flit.data = lcg_next();
        flit.tag = next_tag;
        next_tag++;
        sender_credits--;
        push_flit = flit;
        push_valid = 1'b1;
      end else begin
        push_valid = 1'b0;
      end
      @(negedge clk);
      observe_cycle();
      @(posedge clk);
      #1;
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("test %0d %0s: %0d checks, %0d errors", test_count, name,
             check_count - mark_checks, error_count - mark_errors);
    mark_checks = check_count;
    mark_errors = error_count;
  endtask

  // Once drained, the sender and the counter together hold every credit
  task automatic check_drained();
    if (model_q.size() != 0) begin
      flag_error("flits still outstanding after draining");
    end
    check_count++;
    if (sender_credits + credit_status.credit_count != credit_initial) begin
      flag_error("credits were lost or created over the run");
    end
  endtask

  // ----------------------------------------------------------------------
  // Watchdog
  // ----------------------------------------------------------------------

  initial begin
    #((total_cycles + 100) * 10ns);
    $display("timeout: the tests did not finish in time");
    $display("** FAIL **");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] r;
    int mark_grants;
    credit_fifo_types_pkg::credit_status_t exp_cred;
    credit_initial = credit_fifo_cfg_pkg::depth_credit;
    credit_withhold = '0;
    // Stall keeps push_credit low so the reset state can be seen
    push_credit_stall = 1'b1;
    push_valid = 1'b0;
    push_flit = '0;
    pop_ready = 1'b0;
    lcg_state = 32'd26988;
    next_tag = '0;
    prev_stalled = 1'b0;
    prev_flit = '0;
    sender_credits = 0;
    granted_total = 0;
    pushed_total = 0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    mark_errors = 0;
    mark_checks = 0;

    @(negedge reset);
    run_cycle(1'b0, 1'b0);
    check_bit(pop_valid, 1'b0, "pop_valid after reset");
    check_bit(push_credit, 1'b0, "push_credit after reset");
    check_bit(occupancy.empty, 1'b1, "empty after reset");
    check_bit(occupancy.full, 1'b0, "full after reset");
    exp_cred.credit_count = credit_initial;
    exp_cred.credit_available = credit_initial;
    check_credit(credit_status, exp_cred);
    report_test("reset state");

    push_credit_stall = 1'b0;
    repeat (random_cycles) begin
      r = lcg_next();
      run_cycle(r[21], r[17]);
    end
    report_test("ordering and integrity");

    repeat (drain_cycles) run_cycle(1'b0, 1'b1);
    check_drained();
    report_test("credit conservation");

    // With the consumer stalled, the RAM fills and grants dry up
    repeat (fill_cycles) run_cycle(1'b1, 1'b0);
    check_bit(occupancy.full, 1'b1, "full under back-pressure");
    check_bit(push_credit, 1'b0, "push_credit under back-pressure");
    repeat (drain_cycles) run_cycle(1'b0, 1'b1);
    check_drained();
    report_test("back-pressure");

    mark_grants = granted_total;
    credit_withhold = credit_initial;
    repeat (phase_cycles) run_cycle(1'b1, 1'b1);
    credit_withhold = '0;
    push_credit_stall = 1'b1;
    repeat (phase_cycles) run_cycle(1'b0, 1'b1);
    if (granted_total != mark_grants) begin
      flag_error("credits granted while withheld or stalled");
    end
    // Partial withhold: grants resume and stop with three credits kept back
    push_credit_stall = 1'b0;
    credit_withhold = 3;
    repeat (phase_cycles) run_cycle(1'b0, 1'b1);
    exp_cred.credit_count = 3;
    exp_cred.credit_available = '0;
    check_credit(credit_status, exp_cred);
    credit_withhold = '0;
    repeat (phase_cycles) run_cycle(1'b0, 1'b1);
    check_drained();
    report_test("withhold and stall");

    repeat (skew_cycles) begin
      r = lcg_next();
      run_cycle(r[20], r[9] & r[10]);
    end
    repeat (drain_cycles) run_cycle(1'b0, 1'b1);
    check_drained();
    report_test("occupancy tracking");

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
/* Testbench clock and reset source: 10 ns clock, reset held
   high for the first two rising edges. */

`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam realtime half_period = 5ns;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // Reset drops 1 ns after the second edge, like every other input
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire
